// ==== Makefile ====
TOP := tb_fetch_front_end

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f fetch_front_end.f \
		--top-module $(TOP) -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^test passed$$"

clean:
	rm -rf obj_dir

// ==== fetch_front_end.f ====
logic/core_pkg.sv
logic/imem_pkg.sv
logic/fetch_pc_gen.sv
logic/fetch_tag_queue.sv
logic/instr_buffer.sv
logic/fetch_front_end.sv
tests/tb_imem_model.sv
tests/tb_fetch_front_end.sv

// ==== logic/core_pkg.sv ====
`default_nettype none

// widths and constants shared by every stage of the fetch front end
package core_pkg;

    ////////////////////////////////////////
    // basic vector types
    ////////////////////////////////////////

    // byte address of one instruction
    typedef logic [31:0] addr_t;

    // one instruction word
    typedef logic [31:0] instr_t;

    // valid lanes of a fetch group with bit 0 as the older lane
    typedef logic [1:0] lane_mask_t;

    ////////////////////////////////////////
    // fetch constants
    ////////////////////////////////////////

    // first fetch address out of reset
    localparam addr_t RESET_PC = 32'h1C00_0000;

    // word slot in a 16-byte block where a group shrinks to one lane
    localparam logic [1:0] LAST_SLOT = 2'd3;

    // one-lane group at the block end
    localparam lane_mask_t MASK_ONE = 2'b01;

    // full dual-issue group
    localparam lane_mask_t MASK_TWO = 2'b11;

    // pc steps for the two group sizes
    localparam addr_t STEP_ONE = 32'd4;
    localparam addr_t STEP_TWO = 32'd8;

endpackage

`default_nettype wire

// ==== logic/fetch_front_end.sv ====
`timescale 1ns/1ps
`default_nettype none

// dual-issue fetch front end chaining pc gen, imem port, tag queue and buffer
module fetch_front_end (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_redirect_valid,
    input  core_pkg::addr_t      i_redirect_pc,
    input  logic                 i_imem_req_ready,
    output logic                 o_imem_req_valid,
    output core_pkg::addr_t      o_imem_req_addr,
    input  logic                 i_imem_resp_valid,
    input  imem_pkg::imem_data_t i_imem_resp_data,
    output core_pkg::lane_mask_t o_inst_valid,
    output core_pkg::addr_t      o_inst_pc,
    output core_pkg::instr_t     o_inst_ir0,
    output core_pkg::instr_t     o_inst_ir1,
    input  logic                 i_inst_ready
);

    ////////////////////////////////////////
    // internal nets
    ////////////////////////////////////////

    logic                 can_issue;
    logic                 req_fire;
    core_pkg::lane_mask_t req_mask;
    logic                 wr_valid;
    core_pkg::addr_t      wr_pc;
    core_pkg::lane_mask_t wr_mask;
    core_pkg::instr_t     wr_ir0;
    core_pkg::instr_t     wr_ir1;
    imem_pkg::cnt_t       buf_count;

    fetch_pc_gen u_pc_gen (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_redirect_valid (i_redirect_valid),
        .i_redirect_pc    (i_redirect_pc),
        .i_can_issue      (can_issue),
        .i_imem_req_ready (i_imem_req_ready),
        .o_imem_req_valid (o_imem_req_valid),
        .o_imem_req_addr  (o_imem_req_addr),
        .o_req_fire       (req_fire),
        .o_req_mask       (req_mask)
    );

    // request address doubles as the tag pc
    fetch_tag_queue u_tag_queue (
        .clk               (clk),
        .i_rst_n           (i_rst_n),
        .i_redirect_valid  (i_redirect_valid),
        .i_req_fire        (req_fire),
        .i_req_pc          (o_imem_req_addr),
        .i_req_mask        (req_mask),
        .i_imem_resp_valid (i_imem_resp_valid),
        .i_imem_resp_data  (i_imem_resp_data),
        .i_buf_count       (buf_count),
        .o_can_issue       (can_issue),
        .o_wr_valid        (wr_valid),
        .o_wr_pc           (wr_pc),
        .o_wr_mask         (wr_mask),
        .o_wr_ir0          (wr_ir0),
        .o_wr_ir1          (wr_ir1)
    );

    instr_buffer u_instr_buffer (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_redirect_valid (i_redirect_valid),
        .i_wr_valid       (wr_valid),
        .i_wr_pc          (wr_pc),
        .i_wr_mask        (wr_mask),
        .i_wr_ir0         (wr_ir0),
        .i_wr_ir1         (wr_ir1),
        .i_inst_ready     (i_inst_ready),
        .o_count          (buf_count),
        .o_inst_valid     (o_inst_valid),
        .o_inst_pc        (o_inst_pc),
        .o_inst_ir0       (o_inst_ir0),
        .o_inst_ir1       (o_inst_ir1)
    );

endmodule

`default_nettype wire

// ==== logic/fetch_pc_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

// fetch pc register, next-pc prediction and the imem request channel
module fetch_pc_gen (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_redirect_valid,
    input  core_pkg::addr_t      i_redirect_pc,
    input  logic                 i_can_issue,
    input  logic                 i_imem_req_ready,
    output logic                 o_imem_req_valid,
    output core_pkg::addr_t      o_imem_req_addr,
    output logic                 o_req_fire,
    output core_pkg::lane_mask_t o_req_mask
);

    core_pkg::addr_t      pc_q;
    core_pkg::addr_t      pc_next;
    core_pkg::lane_mask_t lane_mask;
    logic                 last_slot;
    logic                 run_q;    // set one edge after reset release
    logic                 req_valid;

    ////////////////////////////////////////
    // block-end rule
    ////////////////////////////////////////

    // only one instruction fits in the last word of a 16-byte block
    assign last_slot = (pc_q[3:2] == core_pkg::LAST_SLOT);

    assign lane_mask = last_slot ? core_pkg::MASK_ONE : core_pkg::MASK_TWO;
    assign pc_next   = pc_q + (last_slot ? core_pkg::STEP_ONE : core_pkg::STEP_TWO);

    ////////////////////////////////////////
    // request channel
    ////////////////////////////////////////

    // credit only ever rises while a request is held, so valid stays up
    // until the transfer; a redirect pulls the held request back
    assign req_valid = run_q & i_can_issue & ~i_redirect_valid;

    assign o_imem_req_valid = req_valid;
    assign o_imem_req_addr  = pc_q;              // stable while held
    assign o_req_fire       = req_valid & i_imem_req_ready;
    assign o_req_mask       = lane_mask;

    ////////////////////////////////////////
    // pc register
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            run_q <= 1'b0;
            pc_q  <= core_pkg::RESET_PC;
        end else begin
            run_q <= 1'b1;
            if (i_redirect_valid) begin
                pc_q <= i_redirect_pc;           // redirect beats everything
            end else if (o_req_fire) begin
                pc_q <= pc_next;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/fetch_tag_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

// in-flight request tags, matched to in-order imem responses
module fetch_tag_queue (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_redirect_valid,
    input  logic                 i_req_fire,
    input  core_pkg::addr_t      i_req_pc,
    input  core_pkg::lane_mask_t i_req_mask,
    input  logic                 i_imem_resp_valid,
    input  imem_pkg::imem_data_t i_imem_resp_data,
    input  imem_pkg::cnt_t       i_buf_count,
    output logic                 o_can_issue,
    output logic                 o_wr_valid,
    output core_pkg::addr_t      o_wr_pc,
    output core_pkg::lane_mask_t o_wr_mask,
    output core_pkg::instr_t     o_wr_ir0,
    output core_pkg::instr_t     o_wr_ir1
);

    // tag payload storage
    core_pkg::addr_t      tag_pc   [imem_pkg::MAX_OUTSTANDING];
    core_pkg::lane_mask_t tag_mask [imem_pkg::MAX_OUTSTANDING];

    logic [imem_pkg::MAX_OUTSTANDING-1:0]         tag_kill;
    logic [$clog2(imem_pkg::MAX_OUTSTANDING)-1:0] wr_ptr;
    logic [$clog2(imem_pkg::MAX_OUTSTANDING)-1:0] rd_ptr;
    imem_pkg::cnt_t                               outst_q;
    imem_pkg::cnt_t                               credit_sum;

    ////////////////////////////////////////
    // issue credit
    ////////////////////////////////////////

    // every request in flight must find a free buffer slot on return
    assign credit_sum  = outst_q + i_buf_count;
    assign o_can_issue = (outst_q < imem_pkg::cnt_t'(imem_pkg::MAX_OUTSTANDING)) &&
                         (credit_sum < imem_pkg::cnt_t'(imem_pkg::BUF_DEPTH));

    ////////////////////////////////////////
    // response side
    ////////////////////////////////////////

    // responses come back in order so the head tag owns each one
    assign o_wr_valid = i_imem_resp_valid & ~tag_kill[rd_ptr];
    assign o_wr_pc    = tag_pc[rd_ptr];
    assign o_wr_mask  = tag_mask[rd_ptr];
    assign o_wr_ir0   = i_imem_resp_data[31:0];    // word at pc
    assign o_wr_ir1   = i_imem_resp_data[63:32];   // word at pc + 4

    always_ff @(posedge clk) begin
        if (i_req_fire) begin
            tag_pc[wr_ptr]   <= i_req_pc;
            tag_mask[wr_ptr] <= i_req_mask;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            outst_q  <= '0;
            tag_kill <= '0;
        end else begin
            if (i_req_fire) begin
                wr_ptr <= wr_ptr + 1'b1;             // depth is a power of two
            end
            if (i_imem_resp_valid) begin
                rd_ptr <= rd_ptr + 1'b1;             // killed ones pop too
            end

            // fire is held off during a redirect, so no new tag is lost here
            if (i_redirect_valid) begin
                tag_kill <= '1;
            end else if (i_req_fire) begin
                tag_kill[wr_ptr] <= 1'b0;
            end

            case ({i_req_fire, i_imem_resp_valid})
                2'b10:   outst_q <= outst_q + imem_pkg::cnt_t'(1);
                2'b01:   outst_q <= outst_q - imem_pkg::cnt_t'(1);
                default: outst_q <= outst_q;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/imem_pkg.sv ====
`default_nettype none

// instruction memory port and queue sizing
package imem_pkg;

    // lower word at the request address and upper word at address + 4
    typedef logic [63:0] imem_data_t;

    // entry or request count wide enough for in-flight plus buffered
    typedef logic [3:0] cnt_t;

    ////////////////////////////////////////
    // depths
    ////////////////////////////////////////

    // requests allowed in flight at once
    localparam int MAX_OUTSTANDING = 4;

    // instruction buffer entries
    localparam int BUF_DEPTH = 8;

endpackage

`default_nettype wire

// ==== logic/instr_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

// fifo of fetched groups whose head feeds decode
module instr_buffer (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_redirect_valid,
    input  logic                 i_wr_valid,
    input  core_pkg::addr_t      i_wr_pc,
    input  core_pkg::lane_mask_t i_wr_mask,
    input  core_pkg::instr_t     i_wr_ir0,
    input  core_pkg::instr_t     i_wr_ir1,
    input  logic                 i_inst_ready,
    output imem_pkg::cnt_t       o_count,
    output core_pkg::lane_mask_t o_inst_valid,
    output core_pkg::addr_t      o_inst_pc,
    output core_pkg::instr_t     o_inst_ir0,
    output core_pkg::instr_t     o_inst_ir1
);

    core_pkg::addr_t      buf_pc   [imem_pkg::BUF_DEPTH];
    core_pkg::lane_mask_t buf_mask [imem_pkg::BUF_DEPTH];
    core_pkg::instr_t     buf_ir0  [imem_pkg::BUF_DEPTH];
    core_pkg::instr_t     buf_ir1  [imem_pkg::BUF_DEPTH];

    logic [$clog2(imem_pkg::BUF_DEPTH)-1:0] wr_ptr;
    logic [$clog2(imem_pkg::BUF_DEPTH)-1:0] rd_ptr;
    imem_pkg::cnt_t                         count_q;
    logic                                   not_empty;
    logic                                   pop;

    ////////////////////////////////////////
    // decode port
    ////////////////////////////////////////

    assign not_empty = (count_q != '0);
    assign pop       = not_empty & i_inst_ready;

    assign o_inst_valid = not_empty ? buf_mask[rd_ptr] : 2'b00;
    assign o_inst_pc    = buf_pc[rd_ptr];
    assign o_inst_ir0   = buf_ir0[rd_ptr];
    assign o_inst_ir1   = buf_ir1[rd_ptr];     // lane 1 at pc + 4
    assign o_count      = count_q;

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////

    // the credit keeps writes from ever hitting a full buffer
    always_ff @(posedge clk) begin
        if (i_wr_valid) begin
            buf_pc[wr_ptr]   <= i_wr_pc;
            buf_mask[wr_ptr] <= i_wr_mask;
            buf_ir0[wr_ptr]  <= i_wr_ir0;
            buf_ir1[wr_ptr]  <= i_wr_ir1;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_q <= '0;
        end else if (i_redirect_valid) begin
            // flush drops any wrong-path write on this edge
            rd_ptr  <= wr_ptr;
            count_q <= '0;
        end else begin
            if (i_wr_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({i_wr_valid, pop})
                2'b10:   count_q <= count_q + imem_pkg::cnt_t'(1);
                2'b01:   count_q <= count_q - imem_pkg::cnt_t'(1);
                default: count_q <= count_q;   // push and pop cancel
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_fetch_front_end.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_front_end;

    localparam int          NUM_ROWS = 6;
    localparam logic [31:0] WORD_KEY = 32'hA5A5_A5A5;

    typedef struct packed {
        logic            redir;     // redirect before consuming
        core_pkg::addr_t target;
        logic [15:0]     groups;    // groups to accept
        logic            stall;     // random decode ready
    } row_t;

    row_t rows [NUM_ROWS];

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 redirect_valid;
    core_pkg::addr_t      redirect_pc;
    logic                 req_valid;
    logic                 req_ready;
    core_pkg::addr_t      req_addr;
    logic                 resp_valid;
    imem_pkg::imem_data_t resp_data;
    core_pkg::lane_mask_t inst_valid;
    core_pkg::addr_t      inst_pc;
    core_pkg::instr_t     inst_ir0;
    core_pkg::instr_t     inst_ir1;
    logic                 inst_ready;
    logic                 table_ready;
    logic                 held;
    core_pkg::addr_t      held_addr;
    logic [15:0]          lfsr_q;

    fetch_front_end dut0 (
        .clk (clk), .i_rst_n (rst_n),
        .i_redirect_valid (redirect_valid), .i_redirect_pc (redirect_pc),
        .i_imem_req_ready (req_ready), .o_imem_req_valid (req_valid),
        .o_imem_req_addr (req_addr),
        .i_imem_resp_valid (resp_valid), .i_imem_resp_data (resp_data),
        .o_inst_valid (inst_valid), .o_inst_pc (inst_pc),
        .o_inst_ir0 (inst_ir0), .o_inst_ir1 (inst_ir1), .i_inst_ready (inst_ready)
    );

    tb_imem_model imem0 (
        .clk (clk), .i_rst_n (rst_n),
        .i_req_valid (req_valid), .i_req_addr (req_addr), .o_req_ready (req_ready),
        .o_resp_valid (resp_valid), .o_resp_data (resp_data)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end
        return state >> 1;
    endfunction

    task automatic draw_bit(output logic bit_out);
        lfsr_q  = lfsr_step(lfsr_q);
        bit_out = lfsr_q[0];
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    // one lane in the last word of a 16-byte block
    task automatic check_group(input core_pkg::addr_t pc);
        core_pkg::lane_mask_t mask;
        mask = (pc[3:2] == 2'd3) ? 2'b01 : 2'b11;
        compare_value("o_inst_valid", 32'(inst_valid), 32'(mask));
        compare_value("o_inst_pc", inst_pc, pc);
        compare_value("o_inst_ir0", inst_ir0, pc ^ WORD_KEY);
        if (mask[1]) begin
            compare_value("o_inst_ir1", inst_ir1, (pc + 32'd4) ^ WORD_KEY);
        end
    endtask

    ////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////

    task automatic fill_table();
        rows[0] = '{1'b0, 32'h0000_0000, 16'd24, 1'b0};
        rows[1] = '{1'b0, 32'h0000_0000, 16'd40, 1'b1};   // fills the buffer
        rows[2] = '{1'b1, 32'h1C00_100C, 16'd20, 1'b0};   // starts on a last slot
        rows[3] = '{1'b1, 32'h1C00_2004, 16'd36, 1'b1};
        rows[4] = '{1'b1, 32'h1C00_0008, 16'd16, 1'b0};   // redirect with full buffer
        rows[5] = '{1'b1, 32'h1C00_3FF8, 16'd24, 1'b1};
    endtask

    initial begin
        core_pkg::addr_t exp_pc;
        int              taken;
        logic            b0;
        logic            b1;
        rst_n          = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        inst_ready     = 1'b0;
        held           = 1'b0;
        held_addr      = '0;
        lfsr_q         = 16'd85;
        fill_table();
        table_ready = 1'b1;
        repeat (16) @(negedge clk);
        // both valids stay low through reset
        compare_value("o_imem_req_valid", 32'(req_valid), 32'd0);
        compare_value("o_inst_valid", 32'(inst_valid), 32'd0);
        rst_n  = 1'b1;
        exp_pc = core_pkg::RESET_PC;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (rows[r].redir) begin
                @(negedge clk);
                inst_ready     = 1'b0;
                redirect_valid = 1'b1;
                redirect_pc    = rows[r].target;
                @(negedge clk);
                redirect_valid = 1'b0;
                exp_pc         = rows[r].target;
            end
            taken = 0;
            while (taken < int'(rows[r].groups)) begin
                @(negedge clk);
                if (rows[r].stall) begin
                    draw_bit(b0);
                    draw_bit(b1);
                    inst_ready = b0 & b1;
                end else begin
                    inst_ready = 1'b1;
                end
                // outputs are registered, so this group is taken at the next edge
                if (inst_valid != 2'b00 && inst_ready) begin
                    check_group(exp_pc);
                    exp_pc = (exp_pc[3:2] == 2'd3) ? exp_pc + 32'd4 : exp_pc + 32'd8;
                    taken++;
                end
            end
        end
        @(negedge clk);
        inst_ready = 1'b0;
        $display("test passed");
        $finish;
    end

    // held request keeps its address until it transfers or is redirected
    always @(posedge clk) begin
        if (rst_n) begin
            if (held) begin
                if (req_valid) begin
                    compare_value("o_imem_req_addr", req_addr, held_addr);
                end else if (!redirect_valid) begin
                    $display("request at %h dropped before its transfer", held_addr);
                    $display("test failed");
                    $fatal(1);
                end
            end
            held      = req_valid && !req_ready;
            held_addr = req_addr;
        end
    end

    initial begin
        longint limit;
        int     total;
        wait (table_ready);
        total = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            total += int'(rows[i].groups);
        end
        limit = (longint'(total) * 24 + 400) * 10;   // ns with a wide margin per group
        #(limit);
        $display("watchdog expired after %0d ns, %0d groups planned", limit, total);
        $display("test failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

// ==== tests/tb_imem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

// instruction memory with random request ready and in-order responses
module tb_imem_model (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_req_valid,
    input  core_pkg::addr_t      i_req_addr,
    output logic                 o_req_ready,
    output logic                 o_resp_valid,
    output imem_pkg::imem_data_t o_resp_data
);

    localparam logic [31:0] WORD_KEY = 32'hA5A5_A5A5;

    core_pkg::addr_t pend_addr [$];   // accepted requests in order
    int              pend_due  [$];   // edge count at which each may return
    int              edge_cnt;
    logic            live_q;          // reset level seen at the last rising edge
    logic [15:0]     lfsr_q;

    ////////////////////////////////////////
    // random source
    ////////////////////////////////////////

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end
        return state >> 1;
    endfunction

    task automatic draw_bit(output logic bit_out);
        lfsr_q  = lfsr_step(lfsr_q);
        bit_out = lfsr_q[0];
    endtask

    function automatic core_pkg::instr_t mem_word(input core_pkg::addr_t addr);
        return addr ^ WORD_KEY;
    endfunction

    initial begin
        o_req_ready  = 1'b0;
        o_resp_valid = 1'b0;
        o_resp_data  = '0;
        edge_cnt     = 0;
        live_q       = 1'b0;
        lfsr_q       = 16'd85;
    end

    ////////////////////////////////////////
    // accept on the rising edge
    ////////////////////////////////////////

    always @(posedge clk) begin
        logic b0;
        logic b1;
        int   lat;
        edge_cnt = edge_cnt + 1;
        live_q   = i_rst_n;
        if (i_rst_n && i_req_valid && o_req_ready) begin
            draw_bit(b0);
            draw_bit(b1);
            lat = 1 + int'({b1, b0});                // 1 to 4 cycles
            pend_addr.push_back(i_req_addr);
            pend_due.push_back(edge_cnt + lat - 1);
        end
    end

    // drive ready and the next response between edges
    always @(negedge clk) begin
        logic            b0;
        logic            b1;
        core_pkg::addr_t addr;
        if (!live_q) begin
            o_req_ready  = 1'b0;
            o_resp_valid = 1'b0;
            pend_addr.delete();
            pend_due.delete();
        end else begin
            draw_bit(b0);
            draw_bit(b1);
            o_req_ready = b0 | b1;                  // ready three times in four
            if (pend_due.size() > 0 && pend_due[0] <= edge_cnt) begin
                addr         = pend_addr.pop_front();
                pend_due.delete(0);
                o_resp_valid = 1'b1;
                o_resp_data  = {mem_word(addr + 32'd4), mem_word(addr)};
            end else begin
                o_resp_valid = 1'b0;                 // head of line holds order
            end
        end
    end

endmodule

`default_nettype wire
